//--- common/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // one word on the panel data bus
    typedef logic [15:0] lcd_data_t;

    // delay and phase lengths, in clock cycles
    typedef logic [15:0] lcd_cnt_t;

    // kind of a command word
    // codes match bits 19:16 of the host CMD register
    typedef enum logic [3:0] {
        CMD_END   = 4'd0,
        CMD_INST  = 4'd1,
        CMD_DATA  = 4'd2,
        CMD_DELAY = 4'd3
    } lcd_cmd_e;

    // kind in 19:16, payload in 15:0
    typedef struct packed {
        lcd_cmd_e  kind;
        lcd_data_t data;
    } lcd_word_t;

    // everything that leaves the chip towards the panel
    typedef struct packed {
        logic      rst_n;
        logic      cs_n;
        logic      rs;
        logic      wr_n;
        logic      rd_n;
        lcd_data_t data;
        logic      bl;
    } lcd_pins_t;

    // top level sequencing states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HW_RESET,
        ST_WAKE,
        ST_INIT,
        ST_READY
    } lcd_state_e;

    // kept short, real panels want milliseconds here
    localparam lcd_cnt_t LCD_RST_CYCLES      = 16'd64;
    localparam lcd_cnt_t LCD_WAKE_CYCLES     = 16'd32;
    // 8080 write strobe shape
    localparam lcd_cnt_t LCD_WR_SETUP_CYCLES = 16'd1;
    localparam lcd_cnt_t LCD_WR_LOW_CYCLES   = 16'd2;
    localparam lcd_cnt_t LCD_WR_HIGH_CYCLES  = 16'd1;

    localparam int LCD_INIT_LEN = 12;

    // power-up sequence, delay entries carry the pause in the data field
    localparam lcd_word_t lcd_init_table [LCD_INIT_LEN] = '{
        '{CMD_INST,  16'h0011},
        '{CMD_DELAY, 16'd20},
        '{CMD_INST,  16'h003a},
        '{CMD_DATA,  16'h0055},
        '{CMD_INST,  16'h0036},
        '{CMD_DATA,  16'h0048},
        '{CMD_INST,  16'h0013},
        '{CMD_INST,  16'h0020},
        '{CMD_INST,  16'h0029},
        '{CMD_DELAY, 16'd10},
        '{CMD_INST,  16'h002c},
        '{CMD_END,   16'h0000}
    };

endpackage

`default_nettype wire

//--- common/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // byte address, registers sit on word boundaries
    typedef logic [3:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        wb_addr_t   adr;
        wb_data_t   dat;
        logic [3:0] sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // register map
    localparam wb_addr_t WB_REG_CMD    = 4'h0;
    localparam wb_addr_t WB_REG_STATUS = 4'h4;
    localparam wb_addr_t WB_REG_CTRL   = 4'h8;

    // bit positions inside STATUS and CTRL
    localparam int WB_STAT_DONE_BIT = 0;
    localparam int WB_STAT_BUSY_BIT = 1;
    localparam int WB_CTRL_BL_BIT   = 0;

endpackage

`default_nettype wire

//--- hdl/lcd_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_wb_regs (
    input  logic               clk,
    input  logic               resetn,
    input  wb_pkg::wb_req_t    wb_req_i,
    output wb_pkg::wb_rsp_t    wb_rsp_o,
    input  logic               init_done_i,
    input  logic               engine_busy_i,
    output lcd_pkg::lcd_word_t cmd_o,
    output logic               cmd_valid_o,
    input  logic               cmd_ready_i,
    output logic               backlight_o
);

    logic              ack_q;
    wb_pkg::wb_data_t  rdat_q;
    wb_pkg::wb_data_t  rd_data;
    logic              req;
    logic              sel_cmd;
    logic              sel_status;
    logic              sel_ctrl;
    logic              cmd_write;
    logic              kind_ok;
    logic              fast_ack;
    lcd_pkg::lcd_cmd_e wr_kind;

    // live transfer not yet answered
    // the ack cycle itself is masked so one transfer gets one ack
    assign req = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    assign sel_cmd    = (wb_req_i.adr == wb_pkg::WB_REG_CMD);
    assign sel_status = (wb_req_i.adr == wb_pkg::WB_REG_STATUS);
    assign sel_ctrl   = (wb_req_i.adr == wb_pkg::WB_REG_CTRL);

    // command word straight off the bus, host holds it until ack
    assign wr_kind   = lcd_pkg::lcd_cmd_e'(wb_req_i.dat[19:16]);
    assign kind_ok   = (wr_kind == lcd_pkg::CMD_INST) || (wr_kind == lcd_pkg::CMD_DATA);
    assign cmd_write = req && wb_req_i.we && sel_cmd;
    assign cmd_o     = '{kind: wr_kind, data: wb_req_i.dat[15:0]};

    // only real panel writes stall, and only until the engine takes them
    assign cmd_valid_o = cmd_write && kind_ok && init_done_i;

    // reads, CTRL writes, junk kinds, unmapped: answered next edge
    assign fast_ack = req && !(cmd_write && kind_ok);

    // read mux
    always_comb begin
        rd_data = '0;
        if (sel_status) begin
            rd_data[wb_pkg::WB_STAT_DONE_BIT] = init_done_i;
            rd_data[wb_pkg::WB_STAT_BUSY_BIT] = engine_busy_i;
        end else if (sel_ctrl) begin
            rd_data[wb_pkg::WB_CTRL_BL_BIT] = backlight_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_q       <= 1'b0;
            backlight_o <= 1'b0;
        end else begin
            // cmd ack lands on the accept edge
            ack_q <= fast_ack || (cmd_valid_o && cmd_ready_i);
            if (req && wb_req_i.we && sel_ctrl && wb_req_i.sel[0]) begin
                backlight_o <= wb_req_i.dat[wb_pkg::WB_CTRL_BL_BIT];
            end
        end
    end

    // read data captured alongside the ack
    always_ff @(posedge clk) begin
        if (req && !wb_req_i.we) begin
            rdat_q <= rd_data;
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

//--- lcd/lcd_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_fsm (
    input  logic                clk,
    input  logic                resetn,
    input  logic                tmr_done_i,
    input  lcd_pkg::lcd_cnt_t   pause_i,
    input  logic                pause_valid_i,
    input  logic                seq_done_i,
    output logic                tmr_load_o,
    output lcd_pkg::lcd_cnt_t   tmr_count_o,
    output logic                seq_start_o,
    output logic                seq_step_o,
    output logic                panel_rst_n_o,
    output lcd_pkg::lcd_state_e state_o
);

    lcd_pkg::lcd_state_e state;
    lcd_pkg::lcd_state_e state_nxt;
    // timer already running for the current delay entry
    logic                pause_wait;

    always_comb begin
        state_nxt   = state;
        tmr_load_o  = 1'b0;
        tmr_count_o = pause_i;
        seq_start_o = 1'b0;
        seq_step_o  = 1'b0;
        case (state)
            lcd_pkg::ST_IDLE: begin
                // arm the reset hold as we leave idle
                state_nxt   = lcd_pkg::ST_HW_RESET;
                tmr_load_o  = 1'b1;
                tmr_count_o = lcd_pkg::LCD_RST_CYCLES;
            end
            lcd_pkg::ST_HW_RESET: begin
                if (tmr_done_i) begin
                    state_nxt   = lcd_pkg::ST_WAKE;
                    tmr_load_o  = 1'b1;
                    tmr_count_o = lcd_pkg::LCD_WAKE_CYCLES;
                end
            end
            lcd_pkg::ST_WAKE: begin
                if (tmr_done_i) begin
                    state_nxt   = lcd_pkg::ST_INIT;
                    seq_start_o = 1'b1;
                end
            end
            lcd_pkg::ST_INIT: begin
                if (seq_done_i) begin
                    state_nxt = lcd_pkg::ST_READY;
                end else if (pause_wait) begin
                    // pause over, move the sequencer past the delay entry
                    seq_step_o = tmr_done_i;
                end else if (pause_valid_i) begin
                    tmr_load_o = 1'b1;
                end
            end
            default: begin
                // READY is terminal until the next reset
                state_nxt = state;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= lcd_pkg::ST_IDLE;
            pause_wait <= 1'b0;
        end else begin
            state <= state_nxt;
            if (seq_step_o) begin
                pause_wait <= 1'b0;
            end else if (state == lcd_pkg::ST_INIT && tmr_load_o) begin
                pause_wait <= 1'b1;
            end
        end
    end

    // panel held in reset through idle and the reset hold
    assign panel_rst_n_o = (state != lcd_pkg::ST_IDLE) && (state != lcd_pkg::ST_HW_RESET);
    assign state_o       = state;

endmodule

`default_nettype wire

//--- lcd/lcd_delay_timer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_delay_timer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              load_i,
    input  lcd_pkg::lcd_cnt_t count_i,
    output logic              done_o
);

    lcd_pkg::lcd_cnt_t cnt;
    logic              running;

    // high in the last cycle of the wait, once per load
    assign done_o = running && (cnt == '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (load_i) begin
            // a load always restarts, even mid-count
            // N loaded gives done in the Nth cycle after the load edge
            running <= 1'b1;
            cnt     <= (count_i == '0) ? '0 : count_i - 16'd1;
        end else if (running) begin
            if (cnt == '0) begin
                running <= 1'b0;
            end else begin
                cnt <= cnt - 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- lcd/lcd_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_init_seq (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start_i,
    input  logic               step_i,
    output lcd_pkg::lcd_word_t word_o,
    output logic               word_valid_o,
    input  logic               word_ready_i,
    output lcd_pkg::lcd_cnt_t  pause_o,
    output logic               pause_valid_o,
    output logic               done_o
);

    logic [$clog2(lcd_pkg::LCD_INIT_LEN)-1:0] idx;
    logic                                     active;
    lcd_pkg::lcd_word_t                       entry;
    logic                                     is_word;
    logic                                     is_delay;

    assign entry = lcd_pkg::lcd_init_table[idx];

    assign is_word  = active && ((entry.kind == lcd_pkg::CMD_INST) ||
                                 (entry.kind == lcd_pkg::CMD_DATA));
    assign is_delay = active && (entry.kind == lcd_pkg::CMD_DELAY);

    assign word_o       = entry;
    assign word_valid_o = is_word;

    // pause counts from an idle bus, not from the last accept
    assign pause_o       = entry.data;
    assign pause_valid_o = is_delay && word_ready_i;

    // parked on END
    assign done_o = active && (entry.kind == lcd_pkg::CMD_END);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (start_i) begin
            active <= 1'b1;
            idx    <= '0;
        end else if ((is_word && word_ready_i) || (is_delay && step_i)) begin
            idx <= idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- lcd/lcd_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_write_engine (
    input  logic               clk,
    input  logic               resetn,
    input  lcd_pkg::lcd_word_t cmd_i,
    input  logic               cmd_valid_i,
    output logic               cmd_ready_o,
    output logic               busy_o,
    output logic               cs_n_o,
    output logic               rs_o,
    output logic               wr_n_o,
    output lcd_pkg::lcd_data_t data_o
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SETUP,
        PH_LOW,
        PH_HIGH
    } wr_phase_e;

    wr_phase_e          phase;
    // cycles left in the current phase, minus one
    lcd_pkg::lcd_cnt_t  phase_cnt;
    logic               accept;
    logic               rs_q;
    lcd_pkg::lcd_data_t data_q;

    assign cmd_ready_o = (phase == PH_IDLE);
    assign busy_o      = (phase != PH_IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;

    // cs_n spans setup, strobe low and strobe high
    assign cs_n_o = (phase == PH_IDLE);
    // panel latches on the rising edge leaving PH_LOW
    assign wr_n_o = (phase != PH_LOW);
    assign rs_o   = rs_q;
    assign data_o = data_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase     <= PH_IDLE;
            phase_cnt <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (accept) begin
                        phase     <= PH_SETUP;
                        phase_cnt <= lcd_pkg::LCD_WR_SETUP_CYCLES - 16'd1;
                    end
                end
                PH_SETUP: begin
                    if (phase_cnt == '0) begin
                        phase     <= PH_LOW;
                        phase_cnt <= lcd_pkg::LCD_WR_LOW_CYCLES - 16'd1;
                    end else begin
                        phase_cnt <= phase_cnt - 16'd1;
                    end
                end
                PH_LOW: begin
                    if (phase_cnt == '0) begin
                        phase     <= PH_HIGH;
                        phase_cnt <= lcd_pkg::LCD_WR_HIGH_CYCLES - 16'd1;
                    end else begin
                        phase_cnt <= phase_cnt - 16'd1;
                    end
                end
                default: begin
                    // strobe high, hold time before the next word
                    if (phase_cnt == '0) begin
                        phase <= PH_IDLE;
                    end else begin
                        phase_cnt <= phase_cnt - 16'd1;
                    end
                end
            endcase
        end
    end

    // word held on the pins for the whole cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= cmd_i.data;
            rs_q   <= (cmd_i.kind == lcd_pkg::CMD_DATA);
        end
    end

endmodule

`default_nettype wire

//--- hdl/lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_top (
    input  logic               clk,
    input  logic               resetn,
    input  wb_pkg::wb_req_t    wb_req_i,
    output wb_pkg::wb_rsp_t    wb_rsp_o,
    output lcd_pkg::lcd_pins_t lcd_o
);

    lcd_pkg::lcd_state_e state;
    logic                in_init;
    logic                in_ready;
    // timer
    logic                tmr_load;
    logic                tmr_done;
    lcd_pkg::lcd_cnt_t   tmr_count;
    // sequencer
    logic                seq_start;
    logic                seq_step;
    logic                seq_done;
    logic                seq_valid;
    logic                seq_ready;
    lcd_pkg::lcd_word_t  seq_word;
    lcd_pkg::lcd_cnt_t   pause;
    logic                pause_valid;
    // register slave
    lcd_pkg::lcd_word_t  reg_word;
    logic                reg_valid;
    logic                reg_ready;
    logic                backlight;
    // engine
    lcd_pkg::lcd_word_t  eng_word;
    logic                eng_valid;
    logic                eng_ready;
    logic                eng_busy;
    logic                panel_rst_n;
    logic                cs_n;
    logic                rs;
    logic                wr_n;
    lcd_pkg::lcd_data_t  data;

    assign in_init  = (state == lcd_pkg::ST_INIT);
    assign in_ready = (state == lcd_pkg::ST_READY);

    // engine fed by the init table first, then by the host
    assign eng_word  = in_init ? seq_word : reg_word;
    assign eng_valid = in_init ? seq_valid : (in_ready && reg_valid);
    assign seq_ready = in_init && eng_ready;
    assign reg_ready = in_ready && eng_ready;

    lcd_ctrl_fsm fsm0 (
        .clk           (clk),
        .resetn        (resetn),
        .tmr_done_i    (tmr_done),
        .pause_i       (pause),
        .pause_valid_i (pause_valid),
        .seq_done_i    (seq_done),
        .tmr_load_o    (tmr_load),
        .tmr_count_o   (tmr_count),
        .seq_start_o   (seq_start),
        .seq_step_o    (seq_step),
        .panel_rst_n_o (panel_rst_n),
        .state_o       (state)
    );

    lcd_delay_timer tmr0 (
        .clk     (clk),
        .resetn  (resetn),
        .load_i  (tmr_load),
        .count_i (tmr_count),
        .done_o  (tmr_done)
    );

    lcd_init_seq seq0 (
        .clk           (clk),
        .resetn        (resetn),
        .start_i       (seq_start),
        .step_i        (seq_step),
        .word_o        (seq_word),
        .word_valid_o  (seq_valid),
        .word_ready_i  (seq_ready),
        .pause_o       (pause),
        .pause_valid_o (pause_valid),
        .done_o        (seq_done)
    );

    lcd_wb_regs regs0 (
        .clk           (clk),
        .resetn        (resetn),
        .wb_req_i      (wb_req_i),
        .wb_rsp_o      (wb_rsp_o),
        .init_done_i   (in_ready),
        .engine_busy_i (eng_busy),
        .cmd_o         (reg_word),
        .cmd_valid_o   (reg_valid),
        .cmd_ready_i   (reg_ready),
        .backlight_o   (backlight)
    );

    lcd_write_engine eng0 (
        .clk         (clk),
        .resetn      (resetn),
        .cmd_i       (eng_word),
        .cmd_valid_i (eng_valid),
        .cmd_ready_o (eng_ready),
        .busy_o      (eng_busy),
        .cs_n_o      (cs_n),
        .rs_o        (rs),
        .wr_n_o      (wr_n),
        .data_o      (data)
    );

    // no panel reads, rd_n parked high
    assign lcd_o = '{
        rst_n: panel_rst_n,
        cs_n:  cs_n,
        rs:    rs,
        wr_n:  wr_n,
        rd_n:  1'b1,
        data:  data,
        bl:    backlight
    };

endmodule

`default_nettype wire

//--- test/lcd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_checker (
    input logic               clk,
    input logic               resetn,
    input lcd_pkg::lcd_pins_t lcd_i,
    input wb_pkg::wb_rsp_t    wb_rsp_i
);

    // {min gap before the write, rs, data}
    logic [32:0]       exp_q [$];
    logic [32:0]       exp_w;
    int                errors = 0;
    // reset state as seen at the last rising edge
    logic              in_reset = 1'b0;
    logic              running = 1'b0;
    logic              wr_n_q = 1'b1;
    lcd_pkg::lcd_cnt_t low_cnt = '0;
    lcd_pkg::lcd_cnt_t rst_low_cnt = '0;
    logic              rst_checked = 1'b0;
    // cycles since the previous strobe rise
    logic [31:0]       gap_cnt = '0;

    task automatic expect_word(input logic rs, input lcd_pkg::lcd_data_t data,
                               input lcd_pkg::lcd_cnt_t min_gap);
        exp_q.push_back({min_gap, rs, data});
    endtask

    task automatic compare_read(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic int error_count();
        return errors;
    endfunction

    always @(posedge clk) begin
        in_reset <= !resetn;
        running  <= resetn;
    end

    // pins come from registers, so mid-cycle is a quiet place to look
    always @(negedge clk) begin
        if (in_reset) begin
            if (lcd_i.rst_n !== 1'b0 || lcd_i.cs_n !== 1'b1 || lcd_i.wr_n !== 1'b1 ||
                lcd_i.rd_n !== 1'b1 || lcd_i.bl !== 1'b0 || wb_rsp_i.ack !== 1'b0) begin
                errors++;
                $display("ERROR @%0t: outputs not at reset values, pins %h ack %b",
                         $time, lcd_i, wb_rsp_i.ack);
            end
            rst_low_cnt = '0;
            rst_checked = 1'b0;
            wr_n_q      = 1'b1;
        end else if (running) begin
            // length of the panel reset hold
            if (!rst_checked) begin
                if (lcd_i.rst_n === 1'b0) begin
                    rst_low_cnt++;
                end else begin
                    rst_checked = 1'b1;
                    if (rst_low_cnt != lcd_pkg::LCD_RST_CYCLES) begin
                        errors++;
                        $display("ERROR @%0t: panel reset low for %0d cycles, expected %0d",
                                 $time, rst_low_cnt, lcd_pkg::LCD_RST_CYCLES);
                    end
                end
            end
            if (lcd_i.rd_n !== 1'b1) begin
                errors++;
                $display("ERROR @%0t: read strobe driven low", $time);
            end
            gap_cnt++;
            if (lcd_i.wr_n === 1'b0) begin
                low_cnt++;
                if (lcd_i.cs_n !== 1'b0) begin
                    errors++;
                    $display("ERROR @%0t: cs_n high while wr_n is low", $time);
                end
            end else if (wr_n_q === 1'b0) begin
                // strobe just rose, the panel latched rs and data here
                if (low_cnt != lcd_pkg::LCD_WR_LOW_CYCLES || lcd_i.cs_n !== 1'b0) begin
                    errors++;
                    $display("ERROR @%0t: strobe low %0d cycles with cs_n %b, expected %0d",
                             $time, low_cnt, lcd_i.cs_n, lcd_pkg::LCD_WR_LOW_CYCLES);
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR @%0t: unexpected panel write rs %b data %h",
                             $time, lcd_i.rs, lcd_i.data);
                end else begin
                    exp_w = exp_q.pop_front();
                    if ({lcd_i.rs, lcd_i.data} !== exp_w[16:0]) begin
                        errors++;
                        $display("ERROR @%0t: panel write rs %b data %h, expected rs %b data %h",
                                 $time, lcd_i.rs, lcd_i.data, exp_w[16], exp_w[15:0]);
                    end
                    if (gap_cnt <= 32'(exp_w[32:17])) begin
                        errors++;
                        $display("ERROR @%0t: write %0d cycles after the last, pause is %0d",
                                 $time, gap_cnt, exp_w[32:17]);
                    end
                end
                low_cnt = '0;
                gap_cnt = '0;
            end
            wr_n_q = lcd_i.wr_n;
        end
    end

endmodule

`default_nettype wire

//--- test/lcd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_tb;

    localparam int ACK_TIMEOUT   = 200;
    localparam int STATUS_POLLS  = 500;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int HOST_WRITES   = 20;

    logic               clk = 1'b0;
    logic               resetn;
    wb_pkg::wb_req_t    wb_req;
    wb_pkg::wb_rsp_t    wb_rsp;
    lcd_pkg::lcd_pins_t lcd;
    // raised by any wait that runs out
    // stimulus after it is skipped
    logic               timeout_hit = 1'b0;

    always #4 clk = ~clk;

    lcd_top dut0 (
        .clk      (clk),
        .resetn   (resetn),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .lcd_o    (lcd)
    );

    lcd_checker chk0 (
        .clk      (clk),
        .resetn   (resetn),
        .lcd_i    (lcd),
        .wb_rsp_i (wb_rsp)
    );

    // reference word {reaches the bus, rs, data} for one command word
    function automatic logic [17:0] bus_word(input lcd_pkg::lcd_word_t w);
        logic to_bus;
        to_bus = (w.kind == lcd_pkg::CMD_INST) || (w.kind == lcd_pkg::CMD_DATA);
        return {to_bus, w.kind == lcd_pkg::CMD_DATA, w.data};
    endfunction

    // init writes in table order
    // a delay entry sets the minimum gap before the next word
    task automatic expect_init_words();
        lcd_pkg::lcd_cnt_t gap;
        logic [17:0]       bw;
        gap = '0;
        for (int i = 0; i < lcd_pkg::LCD_INIT_LEN; i++) begin
            if (lcd_pkg::lcd_init_table[i].kind == lcd_pkg::CMD_END) begin
                break;
            end
            bw = bus_word(lcd_pkg::lcd_init_table[i]);
            if (lcd_pkg::lcd_init_table[i].kind == lcd_pkg::CMD_DELAY) begin
                gap = lcd_pkg::lcd_init_table[i].data;
            end else if (bw[17]) begin
                chk0.expect_word(bw[16], bw[15:0], gap);
                gap = '0;
            end
        end
    endtask

    // one classic cycle from one falling edge to a later one
    task automatic wb_access(input logic we, input wb_pkg::wb_addr_t adr,
                             input wb_pkg::wb_data_t dat, output wb_pkg::wb_data_t rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        if (!timeout_hit) begin
            wb_req.cyc = 1'b1;
            wb_req.stb = 1'b1;
            wb_req.we  = we;
            wb_req.adr = adr;
            wb_req.dat = dat;
            wb_req.sel = 4'hf;
            do begin
                @(negedge clk);
                waited++;
            end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
            rdata      = wb_rsp.dat;
            wb_req.cyc = 1'b0;
            wb_req.stb = 1'b0;
            wb_req.we  = 1'b0;
            if (!wb_rsp.ack) begin
                $display("timeout: no Wishbone ack for access to address %h", adr);
                timeout_hit = 1'b1;
            end
        end
    endtask

    task automatic host_cmd(input lcd_pkg::lcd_word_t w);
        logic [17:0]      bw;
        wb_pkg::wb_data_t unused;
        bw = bus_word(w);
        if (bw[17]) begin
            chk0.expect_word(bw[16], bw[15:0], '0);
        end
        wb_access(1'b1, wb_pkg::WB_REG_CMD, {12'h000, w}, unused);
    endtask

    initial begin
        wb_pkg::wb_data_t   rdata;
        logic               done_bit;
        int                 polls;
        int                 cycles;
        lcd_pkg::lcd_word_t w;
        resetn = 1'b0;
        wb_req = '0;
        void'($urandom(25));
        expect_init_words();
        repeat (8) @(negedge clk);
        resetn = 1'b1;

        // panel still in reset hold with nothing done and the engine idle
        wb_access(1'b0, wb_pkg::WB_REG_STATUS, '0, rdata);
        chk0.compare_read("STATUS during startup", rdata, 32'h0);
        done_bit = 1'b0;
        polls    = 0;
        while (!done_bit && polls < STATUS_POLLS && !timeout_hit) begin
            wb_access(1'b0, wb_pkg::WB_REG_STATUS, '0, rdata);
            done_bit = rdata[wb_pkg::WB_STAT_DONE_BIT];
            polls++;
        end
        if (!done_bit && !timeout_hit) begin
            $display("timeout: STATUS never reported init done");
            timeout_hit = 1'b1;
        end

        // random host words
        for (int n = 0; n < HOST_WRITES; n++) begin
            w.kind = ($urandom % 2 == 0) ? lcd_pkg::CMD_INST : lcd_pkg::CMD_DATA;
            w.data = 16'($urandom);
            host_cmd(w);
        end
        // kinds with no bus meaning are acked and dropped
        host_cmd('{kind: lcd_pkg::CMD_END, data: 16'h1234});
        host_cmd('{kind: lcd_pkg::CMD_DELAY, data: 16'h0040});
        host_cmd('{kind: lcd_pkg::lcd_cmd_e'(4'hf), data: 16'hbeef});
        host_cmd('{kind: lcd_pkg::CMD_DATA, data: 16'ha5c3});

        // backlight on and off again
        wb_access(1'b1, wb_pkg::WB_REG_CTRL, 32'h1, rdata);
        chk0.compare_read("bl pin after CTRL write 1", {31'b0, lcd.bl}, 32'h1);
        wb_access(1'b0, wb_pkg::WB_REG_CTRL, '0, rdata);
        chk0.compare_read("CTRL readback", rdata, 32'h1);
        wb_access(1'b1, wb_pkg::WB_REG_CTRL, 32'h0, rdata);
        chk0.compare_read("bl pin after CTRL write 0", {31'b0, lcd.bl}, 32'h0);
        wb_access(1'b0, wb_pkg::WB_REG_CTRL, '0, rdata);
        chk0.compare_read("CTRL readback", rdata, 32'h0);

        // let the last panel writes drain
        cycles = 0;
        while ((chk0.pending() != 0 || lcd.cs_n !== 1'b1) && cycles < DRAIN_TIMEOUT &&
               !timeout_hit) begin
            @(negedge clk);
            cycles++;
        end
        if (chk0.pending() != 0 && !timeout_hit) begin
            $display("timeout: %0d expected panel writes never appeared", chk0.pending());
            timeout_hit = 1'b1;
        end
        repeat (4) @(negedge clk);

        $display("closing report: %0d checker errors, %0d timeouts",
                 chk0.error_count(), timeout_hit);
        if (chk0.error_count() == 0 && !timeout_hit) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lcd_ctrl.f
common/lcd_pkg.sv
common/wb_pkg.sv
hdl/lcd_wb_regs.sv
lcd/lcd_ctrl_fsm.sv
lcd/lcd_delay_timer.sv
lcd/lcd_init_seq.sv
lcd/lcd_write_engine.sv
hdl/lcd_top.sv
test/lcd_checker.sv
test/lcd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the LCD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --top-module lcd_tb \
    -f lcd_ctrl.f --Mdir "$BUILD_DIR" -o lcd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/lcd_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
